//--- flist.f
rtl/lcd_cmd_pkg.sv
rtl/lcd_timing_pkg.sv
rtl/lcd_cmd_fifo.sv
rtl/lcd_text_writer.sv
rtl/lcd_ctrl.sv
rtl/lcd_top.sv
dv/lcd_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the LCD testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module lcd_tb -f flist.f -o lcd_sim \
	&& ./obj_dir/lcd_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }

//--- dv/lcd_tb.sv
module lcd_tb;

	localparam int clk_per_us = 2;
	localparam int fifo_depth = 16;
	localparam int lcd_cols   = 16;
	localparam int clk_period = 40;
	localparam int n_burst1   = 40;	// wraps before the 17th and 33rd character
	localparam int n_burst2   = 20;	// after the clear, wraps once more

	logic       clk;
	logic       arst_n;
	logic       char_valid;
	logic [7:0] char_data;
	logic       clear_req;
	logic       cfg_lines;
	logic       cfg_font;
	logic       cfg_disp_on;
	logic       cfg_cursor;
	logic       cfg_blink;
	logic       cfg_inc;
	logic       cfg_shift;
	logic       queue_full;
	logic       busy;
	logic       e;
	logic       rs;
	logic       rw;
	logic [7:0] lcd_data;

	integer                 seed;
	lcd_cmd_pkg::req_t      req_q[$];	// host requests in push order
	lcd_cmd_pkg::bus_word_t exp_q[$];
	string                  exp_name[$];
	int                     n_seen;
	bit                     ref_ready;
	longint                 wd_limit;

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	lcd_top #(
		.clk_per_us(clk_per_us),
		.fifo_depth(fifo_depth),
		.lcd_cols  (lcd_cols)
	) u_lcd_top (
		.clk        (clk),
		.arst_n     (arst_n),
		.char_valid (char_valid),
		.char_data  (char_data),
		.clear_req  (clear_req),
		.cfg_lines  (cfg_lines),
		.cfg_font   (cfg_font),
		.cfg_disp_on(cfg_disp_on),
		.cfg_cursor (cfg_cursor),
		.cfg_blink  (cfg_blink),
		.cfg_inc    (cfg_inc),
		.cfg_shift  (cfg_shift),
		.queue_full (queue_full),
		.busy       (busy),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data)
	);

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input lcd_cmd_pkg::bus_word_t exp_w,
		input lcd_cmd_pkg::bus_word_t act_w);
		if (act_w !== exp_w) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp_w, act_w);
			abort_run();
		end
	endtask

	task automatic check_width(input string name, input int exp_cyc, input int act_cyc);
		if (act_cyc != exp_cyc) begin
			$display("Mismatch %s e width: expected %0d, actual %0d", name, exp_cyc, act_cyc);
			abort_run();
		end
	endtask

	function automatic void add_word(input string name, input logic rs_v, input logic [7:0] d);
		lcd_cmd_pkg::bus_word_t w;
		w.rs   = rs_v;
		w.rw   = 1'b0;	// reads never issued
		w.data = d;
		exp_q.push_back(w);
		exp_name.push_back(name);
	endfunction

	// expected display traffic from the cfg levels and the request list
	function automatic void build_expected();
		int         col;
		logic       line;
		logic [6:0] next_addr;
		col  = 0;
		line = 1'b0;
		add_word("init function set", 1'b0, 8'(lcd_cmd_pkg::op_func_set)
			| {3'b000, 1'b1, cfg_lines, cfg_font, 2'b00});	// DL = 8-bit bus
		add_word("init display control", 1'b0, 8'(lcd_cmd_pkg::op_disp_ctrl)
			| {5'b00000, cfg_disp_on, cfg_cursor, cfg_blink});
		add_word("init clear", 1'b0, 8'(lcd_cmd_pkg::op_clear));
		add_word("init entry mode", 1'b0, 8'(lcd_cmd_pkg::op_entry_mode)
			| {6'b000000, cfg_inc, cfg_shift});
		foreach (req_q[i]) begin
			if (req_q[i].clr) begin
				add_word("clear", 1'b0, 8'(lcd_cmd_pkg::op_clear));
				col  = 0;
				line = 1'b0;
			end else begin
				if (col == lcd_cols) begin
					next_addr = line ? lcd_cmd_pkg::line1_addr : lcd_cmd_pkg::line2_addr;
					add_word("line wrap", 1'b0, 8'(lcd_cmd_pkg::op_set_ddram) | {1'b0, next_addr});
					line = ~line;
					col  = 0;
				end
				add_word("character", 1'b1, req_q[i].ch);
				col++;
			end
		end
	endfunction

	// twice the nominal run time, in time units
	function automatic longint run_limit();
		longint total_us;
		total_us = lcd_timing_pkg::t_powerup + 4 * lcd_timing_pkg::t_init_pulse
			+ lcd_timing_pkg::t_init_gap1 + lcd_timing_pkg::t_init_gap2
			+ lcd_timing_pkg::t_init_gap3 + lcd_timing_pkg::t_init_gap4;
		foreach (exp_q[i]) begin
			if (i >= 4) begin
				if (!exp_q[i].rs && (exp_q[i].data == 8'(lcd_cmd_pkg::op_clear)
					|| exp_q[i].data == 8'(lcd_cmd_pkg::op_home))) begin
					total_us += lcd_timing_pkg::t_clear;
				end else begin
					total_us += lcd_timing_pkg::t_write;
				end
			end
		end
		return 2 * total_us * clk_per_us * clk_period;
	endfunction

	// one request on the host strobes, held while the queue is full
	task automatic push_req(input lcd_cmd_pkg::req_t q);
		if (q.clr) begin
			clear_req  <= 1'b1;
			char_valid <= 1'b0;
			char_data  <= 8'h00;
		end else begin
			clear_req  <= 1'b0;
			char_valid <= 1'b1;
			char_data  <= q.ch;
		end
		@(negedge clk);
		while (queue_full) @(negedge clk);	// next edge would drop the strobe
		@(posedge clk);
	endtask

	// samples at the falling clock edge, so e fell during the previous cycle
	initial begin : monitor
		logic                   e_prev;
		int                     width;
		int                     exp_width;
		lcd_cmd_pkg::bus_word_t w;
		e_prev = 1'b0;
		width  = 0;
		n_seen = 0;
		forever begin
			@(negedge clk);
			if (e) begin
				width++;
			end else if (e_prev) begin
				w = {rs, rw, lcd_data};
				if (n_seen >= exp_q.size()) begin
					$display("display took an extra bus word %h after %0d words", w, n_seen);
					abort_run();
				end else begin
					exp_width = (n_seen < 4) ? lcd_timing_pkg::t_init_pulse * clk_per_us
						: lcd_timing_pkg::t_en_high * clk_per_us;
					check_word($sformatf("%s #%0d", exp_name[n_seen], n_seen), exp_q[n_seen], w);
					check_width($sformatf("%s #%0d", exp_name[n_seen], n_seen), exp_width, width);
					n_seen++;
				end
				width = 0;
			end
			e_prev = e;
		end
	end

	initial begin : watchdog
		wait (ref_ready);
		#(wd_limit);
		$display("timeout: display transfers still running after %0d time units", wd_limit);
		abort_run();
	end

	initial begin : stimulus
		integer            r;
		lcd_cmd_pkg::req_t q;
		seed       = 32'hab10;
		ref_ready  = 1'b0;
		arst_n     = 1'b0;
		char_valid = 1'b0;
		char_data  = 8'h00;
		clear_req  = 1'b0;
		r           = $random(seed);
		cfg_lines   = r[0];
		cfg_font    = r[1];
		cfg_disp_on = r[2];
		cfg_cursor  = r[3];
		cfg_blink   = r[4];
		cfg_inc     = r[5];
		cfg_shift   = r[6];

		// characters, a clear mid-line, then more characters
		repeat (n_burst1) begin
			r    = $random(seed);
			q.clr = 1'b0;
			q.ch  = r[7:0];
			req_q.push_back(q);
		end
		q.clr = 1'b1;
		q.ch  = 8'h00;
		req_q.push_back(q);
		repeat (n_burst2) begin
			r    = $random(seed);
			q.clr = 1'b0;
			q.ch  = r[7:0];
			req_q.push_back(q);
		end
		build_expected();
		wd_limit  = run_limit();
		ref_ready = 1'b1;

		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		foreach (req_q[i]) begin
			push_req(req_q[i]);	// back to back burst
		end
		char_valid <= 1'b0;
		clear_req  <= 1'b0;

		wait (n_seen == exp_q.size());
		@(negedge clk);
		while (busy) @(negedge clk);
		repeat (lcd_timing_pkg::t_write * clk_per_us) @(negedge clk);	// an extra word would show here
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- rtl/lcd_top.sv
module lcd_top #(
	parameter int clk_per_us = 50,
	parameter int fifo_depth = 16,
	parameter int lcd_cols   = 16
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       char_valid,
	input  logic [7:0] char_data,
	input  logic       clear_req,
	input  logic       cfg_lines,
	input  logic       cfg_font,
	input  logic       cfg_disp_on,
	input  logic       cfg_cursor,
	input  logic       cfg_blink,
	input  logic       cfg_inc,
	input  logic       cfg_shift,
	output logic       queue_full,
	output logic       busy,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data
);

	lcd_cmd_pkg::req_t      wr_req;
	lcd_cmd_pkg::req_t      rd_req;
	logic                   wr_en;
	logic                   rd_en;
	logic                   empty;
	logic                   lcd_enable;
	lcd_cmd_pkg::bus_word_t lcd_bus;

	// clear wins over a character in the same cycle
	assign wr_en  = char_valid || clear_req;
	assign wr_req = clear_req ? {1'b1, 8'h00} : {1'b0, char_data};

	lcd_cmd_fifo #(
		.fifo_depth(fifo_depth)
	) u_lcd_cmd_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.wr_en  (wr_en),
		.wr_data(wr_req),
		.rd_en  (rd_en),
		.rd_data(rd_req),
		.empty  (empty),
		.full   (queue_full)
	);

	lcd_text_writer #(
		.lcd_cols(lcd_cols)
	) u_lcd_text_writer (
		.clk       (clk),
		.arst_n    (arst_n),
		.empty     (empty),
		.rd_data   (rd_req),
		.rd_en     (rd_en),
		.busy      (busy),
		.lcd_enable(lcd_enable),
		.lcd_bus   (lcd_bus)
	);

	lcd_ctrl #(
		.clk_per_us(clk_per_us)
	) u_lcd_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.cfg_lines  (cfg_lines),
		.cfg_font   (cfg_font),
		.cfg_disp_on(cfg_disp_on),
		.cfg_cursor (cfg_cursor),
		.cfg_blink  (cfg_blink),
		.cfg_inc    (cfg_inc),
		.cfg_shift  (cfg_shift),
		.lcd_enable (lcd_enable),
		.lcd_bus    (lcd_bus),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data),
		.busy       (busy)
	);

endmodule

//--- rtl/lcd_ctrl.sv
module lcd_ctrl #(
	parameter int clk_per_us = 50
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   cfg_lines,
	input  logic                   cfg_font,
	input  logic                   cfg_disp_on,
	input  logic                   cfg_cursor,
	input  logic                   cfg_blink,
	input  logic                   cfg_inc,
	input  logic                   cfg_shift,
	input  logic                   lcd_enable,
	input  lcd_cmd_pkg::bus_word_t lcd_bus,
	output logic                   e,
	output logic                   rs,
	output logic                   rw,
	output logic [7:0]             lcd_data,
	output logic                   busy
);

	localparam int u = clk_per_us;
	localparam int powerup_len = lcd_timing_pkg::t_powerup * u;
	localparam int init_len = (4 * lcd_timing_pkg::t_init_pulse + lcd_timing_pkg::t_init_gap1
		+ lcd_timing_pkg::t_init_gap2 + lcd_timing_pkg::t_init_gap3
		+ lcd_timing_pkg::t_init_gap4) * u;
	localparam int cnt_max = (powerup_len > init_len) ? powerup_len : init_len;
	localparam int cnt_w = $clog2(cnt_max + 1);

	// init schedule as cycle offsets from the start of function set
	localparam int fs_end_i = lcd_timing_pkg::t_init_pulse * u;
	localparam int dc_start_i = fs_end_i + lcd_timing_pkg::t_init_gap1 * u;
	localparam int dc_end_i = dc_start_i + lcd_timing_pkg::t_init_pulse * u;
	localparam int clr_start_i = dc_end_i + lcd_timing_pkg::t_init_gap2 * u;
	localparam int clr_end_i = clr_start_i + lcd_timing_pkg::t_init_pulse * u;
	localparam int em_start_i = clr_end_i + lcd_timing_pkg::t_init_gap3 * u;
	localparam int em_end_i = em_start_i + lcd_timing_pkg::t_init_pulse * u;

	localparam logic [cnt_w-1:0] powerup_last = cnt_w'(powerup_len - 1);
	localparam logic [cnt_w-1:0] fs_end = cnt_w'(fs_end_i);
	localparam logic [cnt_w-1:0] dc_start = cnt_w'(dc_start_i);
	localparam logic [cnt_w-1:0] dc_end = cnt_w'(dc_end_i);
	localparam logic [cnt_w-1:0] clr_start = cnt_w'(clr_start_i);
	localparam logic [cnt_w-1:0] clr_end = cnt_w'(clr_end_i);
	localparam logic [cnt_w-1:0] em_start = cnt_w'(em_start_i);
	localparam logic [cnt_w-1:0] em_end = cnt_w'(em_end_i);
	localparam logic [cnt_w-1:0] init_end = cnt_w'(init_len);

	// write slot, offsets from the cycle the word goes on the bus
	localparam logic [cnt_w-1:0] en_on = cnt_w'(lcd_timing_pkg::t_en_setup * u);
	localparam logic [cnt_w-1:0] en_off =
		cnt_w'((lcd_timing_pkg::t_en_setup + lcd_timing_pkg::t_en_high) * u);
	localparam logic [cnt_w-1:0] write_len = cnt_w'(lcd_timing_pkg::t_write * u);
	localparam logic [cnt_w-1:0] clear_len = cnt_w'(lcd_timing_pkg::t_clear * u);

	typedef enum logic [1:0] {
		st_powerup,
		st_init,
		st_ready,
		st_write
	} state_e;

	state_e           state;
	logic [cnt_w-1:0] cnt;
	logic [cnt_w-1:0] cnt_nxt;
	logic             hold_long;	// clear or home in flight
	logic [cnt_w-1:0] hold_len;
	logic [7:0]       func_set_word;
	logic [7:0]       disp_ctrl_word;
	logic [7:0]       entry_word;
	logic             init_e;
	logic [7:0]       init_data;
	logic             is_slow_cmd;

	assign cnt_nxt  = cnt + 1'b1;
	assign hold_len = hold_long ? clear_len : write_len;

	assign func_set_word  = 8'(lcd_cmd_pkg::op_func_set) | {3'b000, 1'b1, cfg_lines, cfg_font, 2'b00};
	assign disp_ctrl_word = 8'(lcd_cmd_pkg::op_disp_ctrl)
		| {5'b00000, cfg_disp_on, cfg_cursor, cfg_blink};
	assign entry_word     = 8'(lcd_cmd_pkg::op_entry_mode) | {6'b000000, cfg_inc, cfg_shift};

	assign is_slow_cmd = !lcd_bus.rs && (lcd_bus.data == 8'(lcd_cmd_pkg::op_clear)
		|| lcd_bus.data == 8'(lcd_cmd_pkg::op_home));

	// e and data for the next init cycle; data stays put through each gap
	always_comb begin
		init_e = (cnt_nxt < fs_end)
			|| (cnt_nxt >= dc_start && cnt_nxt < dc_end)
			|| (cnt_nxt >= clr_start && cnt_nxt < clr_end)
			|| (cnt_nxt >= em_start && cnt_nxt < em_end);
		if (cnt_nxt < dc_start) begin
			init_data = func_set_word;
		end else if (cnt_nxt < clr_start) begin
			init_data = disp_ctrl_word;
		end else if (cnt_nxt < em_start) begin
			init_data = 8'(lcd_cmd_pkg::op_clear);
		end else begin
			init_data = entry_word;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= st_powerup;
			cnt       <= '0;
			hold_long <= 1'b0;
			busy      <= 1'b1;
			e         <= 1'b0;
			rs        <= 1'b0;
			rw        <= 1'b0;
			lcd_data  <= '0;
		end else begin
			case (state)
				st_powerup: begin
					if (cnt == powerup_last) begin
						state    <= st_init;
						cnt      <= '0;
						e        <= 1'b1;		// function set pulse starts
						lcd_data <= func_set_word;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				st_init: begin
					if (cnt_nxt == init_end) begin
						state    <= st_ready;
						cnt      <= '0;
						busy     <= 1'b0;
						e        <= 1'b0;
						lcd_data <= '0;
					end else begin
						cnt      <= cnt_nxt;
						e        <= init_e;
						lcd_data <= init_data;
					end
				end
				st_ready: begin
					if (lcd_enable) begin
						state     <= st_write;
						cnt       <= '0;
						busy      <= 1'b1;
						hold_long <= is_slow_cmd;
						rs        <= lcd_bus.rs;
						rw        <= lcd_bus.rw;
						lcd_data  <= lcd_bus.data;
					end
				end
				st_write: begin
					if (cnt_nxt == hold_len) begin
						state    <= st_ready;
						cnt      <= '0;
						busy     <= 1'b0;
						rs       <= 1'b0;	// bus returns to idle
						rw       <= 1'b0;
						lcd_data <= '0;
					end else begin
						cnt <= cnt_nxt;
						e   <= (cnt_nxt >= en_on) && (cnt_nxt < en_off);
					end
				end
				default: state <= st_powerup;
			endcase
		end
	end

endmodule

//--- rtl/lcd_text_writer.sv
module lcd_text_writer #(
	parameter int lcd_cols = 16
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   empty,
	input  lcd_cmd_pkg::req_t      rd_data,
	output logic                   rd_en,
	input  logic                   busy,
	output logic                   lcd_enable,
	output lcd_cmd_pkg::bus_word_t lcd_bus
);

	localparam int col_w = $clog2(lcd_cols + 1);
	localparam logic [col_w-1:0] col_end = col_w'(lcd_cols);

	typedef enum logic [1:0] {
		st_idle,
		st_send,
		st_wait_start,
		st_wait_done
	} state_e;

	state_e           state;
	logic [col_w-1:0] col;		// next column to be written
	logic             line;		// 0 = top line
	logic [6:0]       wrap_addr;

	// address of the line that follows the current one
	assign wrap_addr = line ? lcd_cmd_pkg::line1_addr : lcd_cmd_pkg::line2_addr;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_idle;
			col        <= '0;
			line       <= 1'b0;
			rd_en      <= 1'b0;
			lcd_enable <= 1'b0;
			lcd_bus    <= '0;
		end else begin
			rd_en      <= 1'b0;
			lcd_enable <= 1'b0;
			case (state)
				st_idle: begin
					if (!empty) begin
						state <= st_send;
						if (rd_data.clr) begin
							lcd_bus <= {2'b00, 8'(lcd_cmd_pkg::op_clear)};
							col     <= '0;
							line    <= 1'b0;
							rd_en   <= 1'b1;
						end else if (col == col_end) begin
							// line is full, move the cursor first and keep the entry
							lcd_bus <= {2'b00, 8'(lcd_cmd_pkg::op_set_ddram) | {1'b0, wrap_addr}};
							col     <= '0;
							line    <= ~line;
						end else begin
							lcd_bus <= {2'b10, 8'(lcd_cmd_pkg::op_write_data) | rd_data.ch};
							col     <= col + 1'b1;
							rd_en   <= 1'b1;
						end
					end
				end
				st_send: begin
					if (!busy) begin		// controller idle for at least a cycle
						lcd_enable <= 1'b1;
						state      <= st_wait_start;
					end
				end
				st_wait_start: begin
					if (busy) begin		// word accepted
						state <= st_wait_done;
					end
				end
				st_wait_done: begin
					if (!busy) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- rtl/lcd_cmd_fifo.sv
module lcd_cmd_fifo #(
	parameter int fifo_depth = 16
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                wr_en,
	input  lcd_cmd_pkg::req_t   wr_data,
	input  logic                rd_en,
	output lcd_cmd_pkg::req_t   rd_data,
	output logic                empty,
	output logic                full
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);
	localparam logic [ptr_w-1:0] ptr_last = ptr_w'(fifo_depth - 1);
	localparam logic [cnt_w-1:0] cnt_full = cnt_w'(fifo_depth);

	lcd_cmd_pkg::req_t mem [fifo_depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic             do_wr;
	logic             do_rd;

	assign do_wr = wr_en && !full;		// drop writes while full
	assign do_rd = rd_en && !empty;

	assign empty   = (count == '0);
	assign full    = (count == cnt_full);
	assign rd_data = mem[rd_ptr];		// valid while not empty

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;	// depth need not be 2^n
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

endmodule

//--- rtl/lcd_timing_pkg.sv
package lcd_timing_pkg;

	// all values in microseconds, scaled by clk_per_us in the controller

	localparam int t_powerup = 500;		// wait after power is applied

	// initialization sequence
	localparam int t_init_pulse = 10;	// e high per init instruction
	localparam int t_init_gap1  = 50;	// after function set
	localparam int t_init_gap2  = 50;	// after display control
	localparam int t_init_gap3  = 200;	// after clear
	localparam int t_init_gap4  = 100;	// after entry mode

	// normal bus writes
	localparam int t_en_setup = 1;		// e low before the pulse
	localparam int t_en_high  = 13;		// e pulse width
	localparam int t_write    = 50;		// whole write slot

	// Clear and return-home run much longer inside the display.
	localparam int t_clear = 200;

endpackage

//--- rtl/lcd_cmd_pkg.sv
package lcd_cmd_pkg;

	// HD44780 instruction codes, option bits are OR-ed in by the user
	typedef enum logic [7:0] {
		op_write_data = 8'h00,	// data write, code comes from the character
		op_clear      = 8'h01,
		op_home       = 8'h02,
		op_entry_mode = 8'h04,	// 000001 I/D S
		op_disp_ctrl  = 8'h08,	// 00001 D C B
		op_func_set   = 8'h20,	// 001 DL N F 00
		op_set_ddram  = 8'h80	// 1 + 7-bit address
	} lcd_op_e;

	// one word on the display bus, sampled on the falling edge of e
	typedef struct packed {
		logic       rs;		// 1 selects the data register
		logic       rw;		// 1 reads, unused here
		logic [7:0] data;
	} bus_word_t;

	// queue entry from the host
	typedef struct packed {
		logic       clr;	// clear request, ch ignored
		logic [7:0] ch;
	} req_t;

	// DDRAM start address of each line on a two-line panel
	localparam logic [6:0] line1_addr = 7'h00;
	localparam logic [6:0] line2_addr = 7'h40;

endpackage
